// File: hw/a2_card_pkg.sv
`default_nettype none

package a2_card_pkg;

    // Apple II bus side
    typedef logic [7:0] bus_data_t;

    // Host register port
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Audio path widths
    typedef logic signed [15:0] audio_sample_t;
    typedef logic [9:0]         card_audio_t;
    typedef logic [12:0]        audio_ext_t;

    // Register map
    localparam apb_addr_t CTRL_ADDR   = 8'h00;
    localparam apb_addr_t BORDER_ADDR = 8'h04;

    // Control register bits
    localparam int CTRL_SPEAKER_BIT = 0;
    localparam int CTRL_GS_BIT      = 1;
    localparam int CTRL_IRQ_BIT     = 2;
    localparam int CTRL_DOUT_BIT    = 3;

    // Card levels sit three bits up in the 13-bit term
    localparam int CARD_AUDIO_SHIFT = 3;

    // Speaker click lands on the top bit of the 13-bit term
    localparam int SPEAKER_SHIFT = 12;

endpackage

`default_nettype wire

// File: hw/video_pkg.sv
`default_nettype none

package video_pkg;

    typedef logic [3:0]  color_index_t;
    typedef logic [11:0] rgb444_t;
    typedef logic [17:0] rgb666_t;
    typedef logic [10:0] fb_width_t;
    typedef logic [9:0]  fb_height_t;

    // Frame geometry per source
    localparam fb_width_t  APPLE_FB_WIDTH  = 11'd560;
    localparam fb_height_t APPLE_FB_HEIGHT = 10'd192;
    localparam fb_width_t  SHR_FB_WIDTH    = 11'd640;
    localparam fb_height_t SHR_FB_HEIGHT   = 10'd200;

    // Border colours, Apple II set first, then the IIgs set
    localparam rgb444_t BORDER_PALETTE [32] = '{
        12'h000, 12'h924, 12'h42a, 12'hd4e,
        12'h064, 12'h888, 12'h39e, 12'hcbf,
        12'h450, 12'hc73, 12'h888, 12'hfac,
        12'h3c2, 12'hcd6, 12'h7ec, 12'hfff,
        // IIgs
        12'h000, 12'hd03, 12'h009, 12'hd2d,
        12'h072, 12'h555, 12'h22f, 12'h6af,
        12'h850, 12'hf60, 12'haaa, 12'hf98,
        12'h1d0, 12'hff0, 12'h4f9, 12'hfff
    };

endpackage

`default_nettype wire

// File: hw/card_cfg_if.sv
`default_nettype none

interface card_cfg_if;

    logic                    speaker_en;
    logic                    gs_mode;
    logic                    irq_en;
    logic                    dout_en;
    video_pkg::color_index_t border_color;

    // Register bank side
    modport ctrl (output speaker_en, gs_mode, irq_en, dout_en, border_color);

    // Consumers of the settings
    modport user (input speaker_en, gs_mode, irq_en, dout_en, border_color);

endinterface

`default_nettype wire

// File: hw/card_config_regs.sv
`default_nettype none

module card_config_regs (
    input  wire                    a2bus_if,
    input  wire                    rst_n_i,
    input  wire                    psel_i,
    input  wire                    penable_i,
    input  wire                    pwrite_i,
    input  a2_card_pkg::apb_addr_t paddr_i,
    input  a2_card_pkg::apb_data_t pwdata_i,
    output a2_card_pkg::apb_data_t prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    card_cfg_if.ctrl               cfg_o
);

    logic [3:0]              ctrl_q;
    video_pkg::color_index_t border_q;

    logic access_w;
    logic ctrl_hit_w;
    logic border_hit_w;

    // Access phase of a transfer
    assign access_w     = psel_i & penable_i;
    assign ctrl_hit_w   = (paddr_i == a2_card_pkg::CTRL_ADDR);
    assign border_hit_w = (paddr_i == a2_card_pkg::BORDER_ADDR);

    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q   <= '0;
            border_q <= '0;
        end else if (access_w && pwrite_i) begin
            if (ctrl_hit_w) begin
                ctrl_q <= pwdata_i[3:0];
            end
            if (border_hit_w) begin
                border_q <= pwdata_i[3:0];
            end
        end
    end

    // Read back, upper bits stay zero
    always_comb begin
        prdata_o = '0;
        if (ctrl_hit_w) begin
            prdata_o = a2_card_pkg::apb_data_t'(ctrl_q);
        end else if (border_hit_w) begin
            prdata_o = a2_card_pkg::apb_data_t'(border_q);
        end
    end

    // No wait states
    assign pready_o  = access_w;
    assign pslverr_o = access_w & ~(ctrl_hit_w | border_hit_w);

    assign cfg_o.speaker_en   = ctrl_q[a2_card_pkg::CTRL_SPEAKER_BIT];
    assign cfg_o.gs_mode      = ctrl_q[a2_card_pkg::CTRL_GS_BIT];
    assign cfg_o.irq_en       = ctrl_q[a2_card_pkg::CTRL_IRQ_BIT];
    assign cfg_o.dout_en      = ctrl_q[a2_card_pkg::CTRL_DOUT_BIT];
    assign cfg_o.border_color = border_q;

endmodule

`default_nettype wire

// File: hw/bus_response.sv
`default_nettype none

module bus_response (
    input  wire                    a2bus_if,
    input  wire                    rst_n_i,
    input  wire                    ssc_rd_i,
    input  wire                    ssp_rd_i,
    input  wire                    mb_rd_i,
    input  a2_card_pkg::bus_data_t ssc_data_i,
    input  a2_card_pkg::bus_data_t ssp_data_i,
    input  a2_card_pkg::bus_data_t mb_data_i,
    input  a2_card_pkg::bus_data_t bus_data_i,
    input  wire                    ssc_irq_n_i,
    input  wire                    ssp_irq_n_i,
    input  wire                    mb_irq_n_i,
    card_cfg_if.user               cfg_i,
    output a2_card_pkg::bus_data_t data_out_o,
    output logic                   data_out_en_o,
    output logic                   irq_n_o
);

    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_out_o    <= '0;
            data_out_en_o <= 1'b0;
            irq_n_o       <= 1'b1;
        end else begin
            // Serial card wins, then sprite, then sound
            data_out_o <= ssc_rd_i ? ssc_data_i :
                          ssp_rd_i ? ssp_data_i :
                          mb_rd_i  ? mb_data_i  : bus_data_i;
            data_out_en_o <= (ssc_rd_i | ssp_rd_i | mb_rd_i) & cfg_i.dout_en;
            // Lines are active low, so AND merges them
            irq_n_o <= cfg_i.irq_en ? (ssc_irq_n_i & ssp_irq_n_i & mb_irq_n_i) : 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/audio_mixer.sv
`default_nettype none

module audio_mixer (
    input  wire                        a2bus_if,
    input  wire                        rst_n_i,
    input  a2_card_pkg::audio_sample_t glu_l_i,
    input  a2_card_pkg::audio_sample_t glu_r_i,
    input  a2_card_pkg::card_audio_t   ssp_audio_i,
    input  a2_card_pkg::card_audio_t   mb_l_i,
    input  a2_card_pkg::card_audio_t   mb_r_i,
    input  wire                        speaker_i,
    card_cfg_if.user                   cfg_i,
    output a2_card_pkg::audio_sample_t audio_l_o,
    output a2_card_pkg::audio_sample_t audio_r_o
);

    a2_card_pkg::audio_ext_t ssp_ext_w;
    a2_card_pkg::audio_ext_t mb_l_ext_w;
    a2_card_pkg::audio_ext_t mb_r_ext_w;
    a2_card_pkg::audio_ext_t spk_ext_w;

    // Unsigned card levels widened into 13-bit terms
    assign ssp_ext_w  = a2_card_pkg::audio_ext_t'(ssp_audio_i) << a2_card_pkg::CARD_AUDIO_SHIFT;
    assign mb_l_ext_w = a2_card_pkg::audio_ext_t'(mb_l_i) << a2_card_pkg::CARD_AUDIO_SHIFT;
    assign mb_r_ext_w = a2_card_pkg::audio_ext_t'(mb_r_i) << a2_card_pkg::CARD_AUDIO_SHIFT;
    assign spk_ext_w  = a2_card_pkg::audio_ext_t'(speaker_i & cfg_i.speaker_en)
                        << a2_card_pkg::SPEAKER_SHIFT;

    // Sums wrap at 16 bits, the terms are zero-extended
    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            audio_l_o <= '0;
            audio_r_o <= '0;
        end else begin
            audio_l_o <= glu_l_i + a2_card_pkg::audio_sample_t'(ssp_ext_w)
                       + a2_card_pkg::audio_sample_t'(mb_l_ext_w)
                       + a2_card_pkg::audio_sample_t'(spk_ext_w);
            audio_r_o <= glu_r_i + a2_card_pkg::audio_sample_t'(ssp_ext_w)
                       + a2_card_pkg::audio_sample_t'(mb_r_ext_w)
                       + a2_card_pkg::audio_sample_t'(spk_ext_w);
        end
    end

endmodule

`default_nettype wire

// File: hw/framebuffer_feed.sv
`default_nettype none

module framebuffer_feed (
    input  wire                     a2bus_if,
    input  wire                     rst_n_i,
    input  wire                     shrg_mode_i,
    input  wire                     scan_vsync_i,
    input  wire                     apple_we_i,
    input  video_pkg::rgb666_t      apple_data_i,
    input  wire                     apple_vsync_i,
    input  wire                     shr_we_i,
    input  video_pkg::rgb666_t      shr_data_i,
    input  wire                     shr_vsync_i,
    card_cfg_if.user                cfg_i,
    output logic                    fb_we_o,
    output video_pkg::rgb666_t      fb_data_o,
    output logic                    fb_vsync_o,
    output video_pkg::fb_width_t    fb_width_o,
    output video_pkg::fb_height_t   fb_height_o,
    output video_pkg::rgb666_t      border_rgb_o
);

    logic               use_shr_q;
    logic [4:0]         border_idx_w;
    video_pkg::rgb444_t border_444_w;

    // Mode only changes at a frame boundary so a frame is never mixed
    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            use_shr_q <= 1'b0;
        end else if (scan_vsync_i) begin
            use_shr_q <= shrg_mode_i;
        end
    end

    assign fb_we_o     = use_shr_q ? shr_we_i    : apple_we_i;
    assign fb_data_o   = use_shr_q ? shr_data_i  : apple_data_i;
    assign fb_vsync_o  = use_shr_q ? shr_vsync_i : apple_vsync_i;
    assign fb_width_o  = use_shr_q ? video_pkg::SHR_FB_WIDTH  : video_pkg::APPLE_FB_WIDTH;
    assign fb_height_o = use_shr_q ? video_pkg::SHR_FB_HEIGHT : video_pkg::APPLE_FB_HEIGHT;

    // IIgs colours live in the upper half of the table
    assign border_idx_w = {cfg_i.gs_mode, cfg_i.border_color};
    assign border_444_w = video_pkg::BORDER_PALETTE[border_idx_w];

    // Each nibble padded with two low zero bits
    always_ff @(posedge a2bus_if or negedge rst_n_i) begin
        if (!rst_n_i) begin
            border_rgb_o <= '0;
        end else begin
            border_rgb_o <= {border_444_w[11:8], 2'b00,
                             border_444_w[7:4],  2'b00,
                             border_444_w[3:0],  2'b00};
        end
    end

endmodule

`default_nettype wire

// File: hw/card_glue_top.sv
`default_nettype none

module card_glue_top (
    input  wire                        a2bus_if,
    input  wire                        rst_n_i,
    // Host register port
    input  wire                        psel_i,
    input  wire                        penable_i,
    input  wire                        pwrite_i,
    input  a2_card_pkg::apb_addr_t     paddr_i,
    input  a2_card_pkg::apb_data_t     pwdata_i,
    output a2_card_pkg::apb_data_t     prdata_o,
    output logic                       pready_o,
    output logic                       pslverr_o,
    // Card bus responses
    input  wire                        ssc_rd_i,
    input  wire                        ssp_rd_i,
    input  wire                        mb_rd_i,
    input  a2_card_pkg::bus_data_t     ssc_data_i,
    input  a2_card_pkg::bus_data_t     ssp_data_i,
    input  a2_card_pkg::bus_data_t     mb_data_i,
    input  a2_card_pkg::bus_data_t     bus_data_i,
    input  wire                        ssc_irq_n_i,
    input  wire                        ssp_irq_n_i,
    input  wire                        mb_irq_n_i,
    output a2_card_pkg::bus_data_t     data_out_o,
    output logic                       data_out_en_o,
    output logic                       irq_n_o,
    // Audio sources
    input  a2_card_pkg::audio_sample_t glu_l_i,
    input  a2_card_pkg::audio_sample_t glu_r_i,
    input  a2_card_pkg::card_audio_t   ssp_audio_i,
    input  a2_card_pkg::card_audio_t   mb_l_i,
    input  a2_card_pkg::card_audio_t   mb_r_i,
    input  wire                        speaker_i,
    output a2_card_pkg::audio_sample_t audio_l_o,
    output a2_card_pkg::audio_sample_t audio_r_o,
    // Framebuffer streams
    input  wire                        shrg_mode_i,
    input  wire                        scan_vsync_i,
    input  wire                        apple_we_i,
    input  video_pkg::rgb666_t         apple_data_i,
    input  wire                        apple_vsync_i,
    input  wire                        shr_we_i,
    input  video_pkg::rgb666_t         shr_data_i,
    input  wire                        shr_vsync_i,
    output logic                       fb_we_o,
    output video_pkg::rgb666_t         fb_data_o,
    output logic                       fb_vsync_o,
    output video_pkg::fb_width_t       fb_width_o,
    output video_pkg::fb_height_t      fb_height_o,
    output video_pkg::rgb666_t         border_rgb_o
);

    card_cfg_if cfg ();

    card_config_regs u_config_regs (.*, .cfg_o(cfg));

    bus_response u_bus_response (.*, .cfg_i(cfg));

    audio_mixer u_audio_mixer (.*, .cfg_i(cfg));

    framebuffer_feed u_framebuffer_feed (.*, .cfg_i(cfg));

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 3;

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset released on a falling edge, like all other stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: test/card_glue_tb.sv
`default_nettype none

module card_glue_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BUS_ITERS   = 600;
    localparam int AUDIO_ITERS = 600;
    localparam int FRAME_ITERS = 400;
    // Register tests, APB writes inside the loops and the border sweep add about 400
    localparam int MAX_CYCLES  = 2 * (BUS_ITERS + AUDIO_ITERS + FRAME_ITERS + 400);

    logic clk;
    logic rst_n;
    logic psel_i, penable_i, pwrite_i, pready_o, pslverr_o;
    a2_card_pkg::apb_addr_t paddr_i;
    a2_card_pkg::apb_data_t pwdata_i, prdata_o;
    logic ssc_rd_i, ssp_rd_i, mb_rd_i, ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i;
    a2_card_pkg::bus_data_t ssc_data_i, ssp_data_i, mb_data_i, bus_data_i, data_out_o;
    logic data_out_en_o, irq_n_o, speaker_i;
    a2_card_pkg::audio_sample_t glu_l_i, glu_r_i, audio_l_o, audio_r_o;
    a2_card_pkg::card_audio_t ssp_audio_i, mb_l_i, mb_r_i;
    logic shrg_mode_i, scan_vsync_i, apple_we_i, apple_vsync_i, shr_we_i, shr_vsync_i;
    logic fb_we_o, fb_vsync_o;
    video_pkg::rgb666_t apple_data_i, shr_data_i, fb_data_o, border_rgb_o;
    video_pkg::fb_width_t fb_width_o;
    video_pkg::fb_height_t fb_height_o;

    // Model of the settings registers and the source latch
    logic [3:0] ctrl_m, border_m;
    logic shr_m;
    a2_card_pkg::bus_data_t exp_dout;
    logic exp_dout_en, exp_irq_n;
    a2_card_pkg::audio_sample_t exp_l, exp_r;
    video_pkg::rgb666_t exp_border;
    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;

    tb_clock_gen clock_gen (.clk_o(clk), .rst_n_o(rst_n));

    card_glue_top UUT (.*, .a2bus_if(clk), .rst_n_i(rst_n));

    function automatic a2_card_pkg::bus_data_t select_bus_data(input logic [2:0] rd,
            input a2_card_pkg::bus_data_t ssc, ssp, mb, bus);
        if (rd[2]) begin
            return ssc;
        end else if (rd[1]) begin
            return ssp;
        end else if (rd[0]) begin
            return mb;
        end
        return bus;
    endfunction

    function automatic logic combine_irq_n(input logic en, input logic [2:0] lines_n);
        return en ? (lines_n == 3'b111) : 1'b1;
    endfunction

    function automatic a2_card_pkg::audio_sample_t mix_channel(
            input a2_card_pkg::audio_sample_t glu, input a2_card_pkg::card_audio_t ssp, mb,
            input logic click);
        logic [15:0] sum;
        sum = 16'(glu) + (16'(ssp) << a2_card_pkg::CARD_AUDIO_SHIFT)
            + (16'(mb) << a2_card_pkg::CARD_AUDIO_SHIFT);
        if (click) begin
            sum = sum + (16'd1 << a2_card_pkg::SPEAKER_SHIFT);
        end
        return sum;
    endfunction

    function automatic video_pkg::rgb666_t convert_border(input logic gs,
            input logic [3:0] color);
        logic [4:0] entry;
        video_pkg::rgb444_t c;
        // IIgs set starts 16 entries in
        entry = 5'(16 * int'(gs) + int'(color));
        c = video_pkg::BORDER_PALETTE[entry];
        return {c[11:8], 2'b00, c[7:4], 2'b00, c[3:0], 2'b00};
    endfunction

    // Packs we, vsync and data of the chosen stream
    function automatic logic [19:0] select_stream(input logic use_shr, input logic [19:0] apple,
            input logic [19:0] shr);
        return use_shr ? shr : apple;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic apb_write(input a2_card_pkg::apb_addr_t addr,
            input a2_card_pkg::apb_data_t data);
        {psel_i, penable_i, pwrite_i} = 3'b101;
        paddr_i = addr;
        pwdata_i = data;
        @(negedge clk);
        penable_i = 1'b1;
        @(negedge clk);
        {psel_i, penable_i} = 2'b00;
    endtask

    task automatic apb_read(input a2_card_pkg::apb_addr_t addr);
        {psel_i, penable_i, pwrite_i} = 3'b100;
        paddr_i = addr;
        @(negedge clk);
        penable_i = 1'b1;
        @(negedge clk);
        {psel_i, penable_i} = 2'b00;
    endtask

    task automatic end_run(input logic timed_out);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        logic unmapped;
        logic [19:0] stream_exp;
        a2_card_pkg::apb_data_t read_exp;
        if (!rst_n) begin
            ctrl_m = '0;
            border_m = '0;
            shr_m = 1'b0;
            exp_dout = '0;
            {exp_dout_en, exp_irq_n} = 2'b01;
            exp_l = '0;
            exp_r = '0;
            exp_border = convert_border(1'b0, 4'h0);
        end else begin
            // Registered outputs hold what the previous edge captured
            compare_value("data_out_o", 32'(data_out_o), 32'(exp_dout));
            compare_value("data_out_en_o", 32'(data_out_en_o), 32'(exp_dout_en));
            compare_value("irq_n_o", 32'(irq_n_o), 32'(exp_irq_n));
            compare_value("audio_l_o", {16'h0, audio_l_o}, {16'h0, exp_l});
            compare_value("audio_r_o", {16'h0, audio_r_o}, {16'h0, exp_r});
            compare_value("border_rgb_o", 32'(border_rgb_o), 32'(exp_border));
            stream_exp = select_stream(shr_m, {apple_we_i, apple_vsync_i, apple_data_i},
                                       {shr_we_i, shr_vsync_i, shr_data_i});
            compare_value("fb_we_o", 32'(fb_we_o), 32'(stream_exp[19]));
            compare_value("fb_vsync_o", 32'(fb_vsync_o), 32'(stream_exp[18]));
            compare_value("fb_data_o", 32'(fb_data_o), 32'(stream_exp[17:0]));
            compare_value("fb_width_o", 32'(fb_width_o), shr_m ? 32'd640 : 32'd560);
            compare_value("fb_height_o", 32'(fb_height_o), shr_m ? 32'd200 : 32'd192);
            compare_value("pready_o", 32'(pready_o), 32'(psel_i & penable_i));
            // Error flag only in the access cycle of an unmapped transfer
            unmapped = (paddr_i != a2_card_pkg::CTRL_ADDR)
                     && (paddr_i != a2_card_pkg::BORDER_ADDR);
            compare_value("pslverr_o", 32'(pslverr_o), 32'(psel_i & penable_i & unmapped));
            if (psel_i && penable_i) begin
                read_exp = (paddr_i == a2_card_pkg::CTRL_ADDR) ? {28'h0, ctrl_m} :
                           (paddr_i == a2_card_pkg::BORDER_ADDR) ? {28'h0, border_m} : 32'h0;
                if (!pwrite_i) begin
                    compare_value("prdata_o", prdata_o, read_exp);
                end
            end
            // Expectations for the next edge use the settings before this one
            exp_dout = select_bus_data({ssc_rd_i, ssp_rd_i, mb_rd_i}, ssc_data_i, ssp_data_i,
                                       mb_data_i, bus_data_i);
            exp_dout_en = (ssc_rd_i | ssp_rd_i | mb_rd_i) & ctrl_m[a2_card_pkg::CTRL_DOUT_BIT];
            exp_irq_n = combine_irq_n(ctrl_m[a2_card_pkg::CTRL_IRQ_BIT],
                                      {ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i});
            exp_l = mix_channel(glu_l_i, ssp_audio_i, mb_l_i,
                                speaker_i & ctrl_m[a2_card_pkg::CTRL_SPEAKER_BIT]);
            exp_r = mix_channel(glu_r_i, ssp_audio_i, mb_r_i,
                                speaker_i & ctrl_m[a2_card_pkg::CTRL_SPEAKER_BIT]);
            exp_border = convert_border(ctrl_m[a2_card_pkg::CTRL_GS_BIT], border_m);
            if (scan_vsync_i) begin
                shr_m = shrg_mode_i;
            end
            if (psel_i && penable_i && pwrite_i && paddr_i == a2_card_pkg::CTRL_ADDR) begin
                ctrl_m = pwdata_i[3:0];
            end else if (psel_i && penable_i && pwrite_i
                         && paddr_i == a2_card_pkg::BORDER_ADDR) begin
                border_m = pwdata_i[3:0];
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            end_run(1'b1);
        end
    end

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        void'($urandom(32'hd356));
        {psel_i, penable_i, pwrite_i} = 3'b000;
        paddr_i = '0;
        pwdata_i = '0;
        {ssc_rd_i, ssp_rd_i, mb_rd_i, speaker_i} = 4'b0000;
        {ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i} = 3'b111;
        {ssc_data_i, ssp_data_i, mb_data_i, bus_data_i} = '0;
        {glu_l_i, glu_r_i, ssp_audio_i, mb_l_i, mb_r_i} = '0;
        {shrg_mode_i, scan_vsync_i, apple_we_i, apple_vsync_i, shr_we_i, shr_vsync_i} = '0;
        {apple_data_i, shr_data_i} = '0;
        wait (rst_n === 1'b1);
        repeat (3) @(negedge clk);
        // Reset state followed by masked read back and unmapped accesses
        apb_read(a2_card_pkg::CTRL_ADDR);
        apb_read(a2_card_pkg::BORDER_ADDR);
        apb_write(a2_card_pkg::CTRL_ADDR, 32'hffff_fff5);
        apb_read(a2_card_pkg::CTRL_ADDR);
        apb_write(a2_card_pkg::BORDER_ADDR, 32'h1234_567a);
        apb_read(a2_card_pkg::BORDER_ADDR);
        apb_write(8'h08, 32'h0000_000f);
        apb_write(8'h01, 32'h0000_0003);
        apb_read(8'h08);
        apb_read(a2_card_pkg::CTRL_ADDR);
        apb_read(a2_card_pkg::BORDER_ADDR);
        for (int i = 0; i < BUS_ITERS; i++) begin
            r1 = $urandom;
            r2 = $urandom;
            if (i % 50 == 0) begin
                apb_write(a2_card_pkg::CTRL_ADDR, {28'h0, r2[11:8]});
            end
            {ssc_rd_i, ssp_rd_i, mb_rd_i} = r1[2:0];
            {ssc_irq_n_i, ssp_irq_n_i, mb_irq_n_i} = r1[5:3];
            {mb_data_i, ssp_data_i, ssc_data_i} = r1[31:8];
            bus_data_i = r2[7:0];
            @(negedge clk);
        end
        for (int i = 0; i < AUDIO_ITERS; i++) begin
            r1 = $urandom;
            r2 = $urandom;
            // Speaker enable flips every 40 samples
            if (i % 40 == 0) begin
                apb_write(a2_card_pkg::CTRL_ADDR,
                          32'((i / 40) % 2) << a2_card_pkg::CTRL_SPEAKER_BIT);
            end
            {glu_r_i, glu_l_i} = r1;
            {speaker_i, mb_r_i, mb_l_i, ssp_audio_i} = r2[30:0];
            @(negedge clk);
        end
        for (int i = 0; i < FRAME_ITERS; i++) begin
            r1 = $urandom;
            r2 = $urandom;
            // Mode request changes halfway between vsync pulses
            if (i % 16 == 8) begin
                shrg_mode_i = ~shrg_mode_i;
            end
            scan_vsync_i = (i % 16 == 15);
            apple_data_i = r1[17:0];
            shr_data_i = r2[17:0];
            {apple_we_i, apple_vsync_i, shr_we_i, shr_vsync_i} = r2[31:28];
            @(negedge clk);
        end
        scan_vsync_i = 1'b0;
        for (int i = 0; i < 32; i++) begin
            apb_write(a2_card_pkg::CTRL_ADDR, 32'(i / 16) << a2_card_pkg::CTRL_GS_BIT);
            apb_write(a2_card_pkg::BORDER_ADDR, 32'(i % 16));
            repeat (2) @(negedge clk);
        end
        end_run(1'b0);
    end

endmodule

`default_nettype wire

// File: card_glue_top.f
hw/a2_card_pkg.sv
hw/video_pkg.sv
hw/card_cfg_if.sv
hw/card_config_regs.sv
hw/bus_response.sv
hw/audio_mixer.sv
hw/framebuffer_feed.sv
hw/card_glue_top.sv
test/tb_clock_gen.sv
test/card_glue_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the card glue testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f card_glue_top.f \
    --top-module card_glue_tb --Mdir obj_dir -o card_glue_sim > "$LOG" 2>&1 \
    && ./obj_dir/card_glue_sim >> "$LOG" 2>&1 \
    || echo "Build or simulation exited with an error" >> "$LOG"

cat "$LOG"
grep -q "TEST RESULT: FAIL" "$LOG" && { echo "Simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" "$LOG" || { echo "No passing result in $LOG"; exit 1; }
echo "Simulation passed"
